/* include/rv_decode_macros.svh */
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// Datapath widths
`define RV_XLEN      32
`define RV_REG_BITS  5

// Major opcodes of the base integer set
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP_IMM   7'b0010011
`define OPC_OP       7'b0110011

// funct7 forms
`define F7_BASE      7'b0000000
`define F7_ALT       7'b0100000  // SUB and SRA/SRAI

// Compressed quadrants, 2'b11 marks a full-width word
`define RVC_Q0       2'b00
`define RVC_Q1       2'b01
`define RVC_Q2       2'b10

`endif

/* verilog/rv_decode_pkg.sv */
`default_nettype none

`include "rv_decode_macros.svh"

package rv_decode_pkg;

	typedef enum logic [3:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store,
		cls_alu_imm,
		cls_alu_reg,
		cls_none
	} insn_class_e;

	typedef enum logic [5:0] {
		op_illegal,
		op_lui, op_auipc, op_jal, op_jalr,
		op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_lb, op_lh, op_lw, op_lbu, op_lhu,
		op_sb, op_sh, op_sw,
		op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
		op_slli, op_srli, op_srai,
		op_add, op_sub, op_sll, op_slt, op_sltu,
		op_xor, op_srl, op_sra, op_or, op_and
	} rv_op_e;

	typedef struct packed {
		logic [`RV_XLEN-1:0] word;
	} fetch_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0]     word;  // Already expanded to 32 bits
		insn_class_e             cls;
		logic [`RV_REG_BITS-1:0] rd;
		logic [`RV_REG_BITS-1:0] rs1;
		logic [`RV_REG_BITS-1:0] rs2;
		logic                    compressed;
	} class_stage_t;

	typedef struct packed {
		rv_op_e                  op;
		logic [`RV_REG_BITS-1:0] rd;
		logic [`RV_REG_BITS-1:0] rs1;
		logic [`RV_REG_BITS-1:0] rs2;
		logic [`RV_XLEN-1:0]     imm;
		logic                    compressed;
	} decoded_t;

endpackage

`default_nettype wire

/* verilog/rvc_expander.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module rvc_expander (
	input  logic [`RV_XLEN-1:0] word,
	output logic [`RV_XLEN-1:0] expanded_word,
	output logic                compressed
);

	logic [15:0]         c;
	logic [4:0]          rd_full;
	logic [4:0]          rs2_full;
	logic [4:0]          rdp;
	logic [4:0]          rs1p;
	logic                ci_zero;
	logic [11:0]         imm_ci;
	logic [11:0]         imm_4spn;
	logic [11:0]         imm_lw;
	logic [11:0]         imm_16sp;
	logic [11:0]         imm_lwsp;
	logic [11:0]         imm_swsp;
	logic [19:0]         imm_lui;
	logic [20:0]         imm_cj;
	logic [12:0]         imm_cb;
	logic [`RV_XLEN-1:0] c_word;

	assign c        = word[15:0];
	assign rd_full  = c[11:7];
	assign rs2_full = c[6:2];
	assign rdp      = {2'b01, c[4:2]};  // x8..x15
	assign rs1p     = {2'b01, c[9:7]};
	assign ci_zero  = ({c[12], c[6:2]} == 6'd0);

	// Scrambled immediates, widened to the RV32I field sizes
	assign imm_ci   = {{6{c[12]}}, c[12], c[6:2]};
	assign imm_4spn = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
	assign imm_lw   = {5'b00000, c[5], c[12:10], c[6], 2'b00};
	assign imm_16sp = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
	assign imm_lwsp = {4'b0000, c[3:2], c[12], c[6:4], 2'b00};
	assign imm_swsp = {4'b0000, c[8:7], c[12:9], 2'b00};
	assign imm_lui  = {{14{c[12]}}, c[12], c[6:2]};
	assign imm_cj   = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
	assign imm_cb   = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};

	always_comb begin
		c_word = '0;  // Reserved encodings stay zero
		case (c[1:0])
			`RVC_Q0: begin
				case (c[15:13])
					3'b000: if (imm_4spn != 12'd0)  // C.ADDI4SPN
						c_word = {imm_4spn, 5'd2, 3'b000, rdp, `OPC_OP_IMM};
					3'b010: c_word = {imm_lw, rs1p, 3'b010, rdp, `OPC_LOAD};  // C.LW
					3'b110: c_word = {imm_lw[11:5], rdp, rs1p, 3'b010, imm_lw[4:0], `OPC_STORE};
					default: c_word = '0;
				endcase
			end
			`RVC_Q1: begin
				case (c[15:13])
					3'b000: c_word = {imm_ci, rd_full, 3'b000, rd_full, `OPC_OP_IMM};  // C.ADDI
					3'b001: c_word = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12],
						5'd1, `OPC_JAL};
					3'b010: c_word = {imm_ci, 5'd0, 3'b000, rd_full, `OPC_OP_IMM};  // C.LI
					3'b011: begin
						if (ci_zero)
							c_word = '0;
						else if (rd_full == 5'd2)  // C.ADDI16SP
							c_word = {imm_16sp, 5'd2, 3'b000, 5'd2, `OPC_OP_IMM};
						else
							c_word = {imm_lui, rd_full, `OPC_LUI};
					end
					3'b100: begin
						case (c[11:10])
							2'b00: if (!c[12])  // C.SRLI
								c_word = {`F7_BASE, c[6:2], rs1p, 3'b101, rs1p, `OPC_OP_IMM};
							2'b01: if (!c[12])  // C.SRAI
								c_word = {`F7_ALT, c[6:2], rs1p, 3'b101, rs1p, `OPC_OP_IMM};
							2'b10: c_word = {imm_ci, rs1p, 3'b111, rs1p, `OPC_OP_IMM};
							default: begin
								if (!c[12]) begin
									case (c[6:5])
										2'b00: c_word = {`F7_ALT, rdp, rs1p, 3'b000, rs1p, `OPC_OP};
										2'b01: c_word = {`F7_BASE, rdp, rs1p, 3'b100, rs1p, `OPC_OP};
										2'b10: c_word = {`F7_BASE, rdp, rs1p, 3'b110, rs1p, `OPC_OP};
										default: c_word = {`F7_BASE, rdp, rs1p, 3'b111, rs1p, `OPC_OP};
									endcase
								end
							end
						endcase
					end
					3'b101: c_word = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12],
						5'd0, `OPC_JAL};  // C.J
					3'b110: c_word = {imm_cb[12], imm_cb[10:5], 5'd0, rs1p, 3'b000,
						imm_cb[4:1], imm_cb[11], `OPC_BRANCH};
					default: c_word = {imm_cb[12], imm_cb[10:5], 5'd0, rs1p, 3'b001,
						imm_cb[4:1], imm_cb[11], `OPC_BRANCH};  // C.BNEZ
				endcase
			end
			`RVC_Q2: begin
				case (c[15:13])
					3'b000: if (!c[12])  // C.SLLI
						c_word = {`F7_BASE, c[6:2], rd_full, 3'b001, rd_full, `OPC_OP_IMM};
					3'b010: if (rd_full != 5'd0)  // C.LWSP
						c_word = {imm_lwsp, 5'd2, 3'b010, rd_full, `OPC_LOAD};
					3'b100: begin
						if (!c[12]) begin
							if (rs2_full == 5'd0) begin
								if (rd_full != 5'd0)  // C.JR
									c_word = {12'd0, rd_full, 3'b000, 5'd0, `OPC_JALR};
							end else begin
								c_word = {`F7_BASE, rs2_full, 5'd0, 3'b000, rd_full, `OPC_OP};
							end
						end else if (rs2_full == 5'd0) begin
							if (rd_full != 5'd0)  // C.JALR, the rd=0 slot is EBREAK
								c_word = {12'd0, rd_full, 3'b000, 5'd1, `OPC_JALR};
						end else begin
							c_word = {`F7_BASE, rs2_full, rd_full, 3'b000, rd_full, `OPC_OP};
						end
					end
					3'b110: c_word = {imm_swsp[11:5], rs2_full, 5'd2, 3'b010, imm_swsp[4:0],
						`OPC_STORE};  // C.SWSP
					default: c_word = '0;
				endcase
			end
			default: c_word = '0;
		endcase
	end

	assign compressed    = (word[1:0] != 2'b11);
	assign expanded_word = compressed ? c_word : word;

endmodule

`default_nettype wire

/* verilog/opcode_classifier.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module opcode_classifier (
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        s1_load,
	input  logic [`RV_XLEN-1:0]         expanded_word,
	input  logic                        compressed,
	output rv_decode_pkg::class_stage_t stage1
);

	rv_decode_pkg::insn_class_e  cls_n;
	rv_decode_pkg::class_stage_t stage_n;
	logic                        reg_known;

	always_comb begin
		case (expanded_word[6:0])
			`OPC_LUI:    cls_n = rv_decode_pkg::cls_lui;
			`OPC_AUIPC:  cls_n = rv_decode_pkg::cls_auipc;
			`OPC_JAL:    cls_n = rv_decode_pkg::cls_jal;
			`OPC_JALR:   cls_n = (expanded_word[14:12] == 3'b000) ?
				rv_decode_pkg::cls_jalr : rv_decode_pkg::cls_none;
			`OPC_BRANCH: cls_n = rv_decode_pkg::cls_branch;
			`OPC_LOAD:   cls_n = rv_decode_pkg::cls_load;
			`OPC_STORE:  cls_n = rv_decode_pkg::cls_store;
			`OPC_OP_IMM: cls_n = rv_decode_pkg::cls_alu_imm;
			`OPC_OP:     cls_n = rv_decode_pkg::cls_alu_reg;
			default:     cls_n = rv_decode_pkg::cls_none;
		endcase
	end

	always_comb begin
		stage_n.word       = expanded_word;
		stage_n.cls        = cls_n;
		stage_n.rd         = expanded_word[11:7];
		stage_n.rs1        = expanded_word[19:15];
		stage_n.rs2        = expanded_word[24:20];
		stage_n.compressed = compressed;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			stage1.cls <= rv_decode_pkg::cls_none;
		end else if (s1_load) begin
			stage1 <= stage_n;
		end
	end

	// Registered opcode recognised, jalr only with funct3 zero
	assign reg_known = (stage1.word[6:0] inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR,
		`OPC_BRANCH, `OPC_LOAD, `OPC_STORE, `OPC_OP_IMM, `OPC_OP}) &&
		!(stage1.word[6:0] == `OPC_JALR && stage1.word[14:12] != 3'b000);

	a_class_known: assert property (@(posedge clk) disable iff (!resetn)
		s1_load |=> reg_known == (stage1.cls != rv_decode_pkg::cls_none))
		else $error("class does not match registered opcode %h", stage1.word[6:0]);

endmodule

`default_nettype wire

/* verilog/insn_decoder.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module insn_decoder (
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        s2_load,
	input  rv_decode_pkg::class_stage_t stage1,
	output rv_decode_pkg::decoded_t     dec
);

	logic [`RV_XLEN-1:0]  w;
	logic [2:0]           f3;
	logic [6:0]           f7;
	logic [`RV_XLEN-1:0]  imm_i, imm_s, imm_b, imm_u, imm_j;
	rv_decode_pkg::rv_op_e op_n;
	logic [`RV_XLEN-1:0]  imm_n;

	assign w  = stage1.word;
	assign f3 = w[14:12];
	assign f7 = w[31:25];

	assign imm_i = {{20{w[31]}}, w[31:20]};
	assign imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
	assign imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	assign imm_u = {w[31:12], 12'b0};
	assign imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

	always_comb begin
		op_n  = rv_decode_pkg::op_illegal;
		imm_n = '0;  // R-type and unknown words carry no immediate
		case (stage1.cls)
			rv_decode_pkg::cls_lui: begin
				op_n  = rv_decode_pkg::op_lui;
				imm_n = imm_u;
			end
			rv_decode_pkg::cls_auipc: begin
				op_n  = rv_decode_pkg::op_auipc;
				imm_n = imm_u;
			end
			rv_decode_pkg::cls_jal: begin
				op_n  = rv_decode_pkg::op_jal;
				imm_n = imm_j;
			end
			rv_decode_pkg::cls_jalr: begin
				op_n  = rv_decode_pkg::op_jalr;
				imm_n = imm_i;
			end
			rv_decode_pkg::cls_branch: begin
				imm_n = imm_b;
				case (f3)
					3'b000:  op_n = rv_decode_pkg::op_beq;
					3'b001:  op_n = rv_decode_pkg::op_bne;
					3'b100:  op_n = rv_decode_pkg::op_blt;
					3'b101:  op_n = rv_decode_pkg::op_bge;
					3'b110:  op_n = rv_decode_pkg::op_bltu;
					3'b111:  op_n = rv_decode_pkg::op_bgeu;
					default: op_n = rv_decode_pkg::op_illegal;
				endcase
			end
			rv_decode_pkg::cls_load: begin
				imm_n = imm_i;
				case (f3)
					3'b000:  op_n = rv_decode_pkg::op_lb;
					3'b001:  op_n = rv_decode_pkg::op_lh;
					3'b010:  op_n = rv_decode_pkg::op_lw;
					3'b100:  op_n = rv_decode_pkg::op_lbu;
					3'b101:  op_n = rv_decode_pkg::op_lhu;
					default: op_n = rv_decode_pkg::op_illegal;
				endcase
			end
			rv_decode_pkg::cls_store: begin
				imm_n = imm_s;
				case (f3)
					3'b000:  op_n = rv_decode_pkg::op_sb;
					3'b001:  op_n = rv_decode_pkg::op_sh;
					3'b010:  op_n = rv_decode_pkg::op_sw;
					default: op_n = rv_decode_pkg::op_illegal;
				endcase
			end
			rv_decode_pkg::cls_alu_imm: begin
				imm_n = imm_i;  // Shifts keep funct7 in the upper bits
				case (f3)
					3'b000: op_n = rv_decode_pkg::op_addi;
					3'b010: op_n = rv_decode_pkg::op_slti;
					3'b011: op_n = rv_decode_pkg::op_sltiu;
					3'b100: op_n = rv_decode_pkg::op_xori;
					3'b110: op_n = rv_decode_pkg::op_ori;
					3'b111: op_n = rv_decode_pkg::op_andi;
					3'b001: if (f7 == `F7_BASE) op_n = rv_decode_pkg::op_slli;
					default: begin
						if (f7 == `F7_BASE)
							op_n = rv_decode_pkg::op_srli;
						else if (f7 == `F7_ALT)
							op_n = rv_decode_pkg::op_srai;
					end
				endcase
			end
			rv_decode_pkg::cls_alu_reg: begin
				if (f7 == `F7_BASE) begin
					case (f3)
						3'b000:  op_n = rv_decode_pkg::op_add;
						3'b001:  op_n = rv_decode_pkg::op_sll;
						3'b010:  op_n = rv_decode_pkg::op_slt;
						3'b011:  op_n = rv_decode_pkg::op_sltu;
						3'b100:  op_n = rv_decode_pkg::op_xor;
						3'b101:  op_n = rv_decode_pkg::op_srl;
						3'b110:  op_n = rv_decode_pkg::op_or;
						default: op_n = rv_decode_pkg::op_and;
					endcase
				end else if (f7 == `F7_ALT && f3 == 3'b000) begin
					op_n = rv_decode_pkg::op_sub;
				end else if (f7 == `F7_ALT && f3 == 3'b101) begin
					op_n = rv_decode_pkg::op_sra;
				end
			end
			default: op_n = rv_decode_pkg::op_illegal;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			dec.op <= rv_decode_pkg::op_illegal;
		end else if (s2_load) begin
			dec.op         <= op_n;
			dec.rd         <= stage1.rd;
			dec.rs1        <= stage1.rs1;
			dec.rs2        <= stage1.rs2;
			dec.imm        <= imm_n;
			dec.compressed <= stage1.compressed;
		end
	end

endmodule

`default_nettype wire

/* verilog/decode_control.sv */
`default_nettype none

module decode_control (
	input  logic clk,
	input  logic resetn,
	input  logic fetch_valid,
	output logic s1_load,
	output logic s2_load,
	output logic dec_valid
);

	logic s1_valid;
	logic s2_valid;

	// Two-deep valid pipe, never stalls
	always_ff @(posedge clk) begin
		if (!resetn) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= fetch_valid;
			s2_valid <= s1_valid;
		end
	end

	assign s1_load   = fetch_valid;
	assign s2_load   = s1_valid;
	assign dec_valid = s2_valid;

	// Every output strobe traces back to a fetch two edges earlier
	a_dec_latency: assert property (@(posedge clk) disable iff (!resetn)
		dec_valid |-> $past(fetch_valid, 2))
		else $error("dec_valid without fetch_valid two cycles earlier");

	a_reset_clear: assert property (@(posedge clk)
		!resetn |=> !s1_valid && !s2_valid)
		else $error("stage valid high after reset cycle");

endmodule

`default_nettype wire

/* verilog/rv_decode_top.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decode_top (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    fetch_valid,
	input  rv_decode_pkg::fetch_t   fetch,
	output logic                    dec_valid,
	output rv_decode_pkg::decoded_t dec
);

	logic                        s1_load;
	logic                        s2_load;
	logic [`RV_XLEN-1:0]         expanded_word;
	logic                        compressed;
	rv_decode_pkg::class_stage_t stage1;

	decode_control u_ctrl (
		.clk         (clk),
		.resetn      (resetn),
		.fetch_valid (fetch_valid),
		.s1_load     (s1_load),
		.s2_load     (s2_load),
		.dec_valid   (dec_valid)
	);

	rvc_expander u_expand (
		.word          (fetch.word),
		.expanded_word (expanded_word),
		.compressed    (compressed)
	);

	opcode_classifier u_class (
		.clk           (clk),
		.resetn        (resetn),
		.s1_load       (s1_load),
		.expanded_word (expanded_word),
		.compressed    (compressed),
		.stage1        (stage1)
	);

	insn_decoder u_dec (
		.clk     (clk),
		.resetn  (resetn),
		.s2_load (s2_load),
		.stage1  (stage1),
		.dec     (dec)
	);

endmodule

`default_nettype wire

/* sim/tb_top.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_LEGAL     = 200;
	localparam int N_COMP      = 300;
	localparam int N_ILLEGAL   = 22;
	localparam int N_RAND      = 400;
	localparam int TOTAL_WORDS = N_LEGAL + N_COMP + N_ILLEGAL + N_RAND;
	localparam int WATCHDOG_NS = (TOTAL_WORDS + 20) * 40 * 2;

	logic                    clk;
	logic                    resetn;
	logic                    fetch_valid;
	rv_decode_pkg::fetch_t   fetch;
	logic                    dec_valid;
	rv_decode_pkg::decoded_t dec;

	rv_decode_pkg::decoded_t exp_q[$];
	bit                      illegal_q[$];
	logic [31:0]             rng;
	logic [1:0]              fv_hist;  // fetch_valid one and two cycles back
	bit                      mon_en;
	int                      push_count;
	int                      pulse_count;
	int                      test_errors;
	int                      total_errors;
	int                      failed_tests;

	logic [31:0] illegal_words [N_ILLEGAL] = '{
		32'h0000_0000, 32'h0000_007f, 32'h0000_000b, 32'h0000_2063,
		32'h0000_3063, 32'h0000_3003, 32'h0000_6003, 32'h0000_7003,
		32'h0000_3023, 32'h0200_0033, 32'h4000_1033, 32'h0000_1067,
		32'h6000_5013, 32'h0200_1013, 32'h0000_0073, 32'h0000_9002,
		32'h0000_2000, 32'h0000_6001, 32'h0000_8002, 32'h0000_9001,
		32'h0000_4002, 32'h0000_001c
	};

	rv_decode_top dut0 (
		.clk         (clk),
		.resetn      (resetn),
		.fetch_valid (fetch_valid),
		.fetch       (fetch),
		.dec_valid   (dec_valid),
		.dec         (dec)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic logic [31:0] sext(input logic [31:0] v, input int msb);
		logic [31:0] r;
		int          i;
		r = v;
		for (i = msb + 1; i < 32; i++)
			r[i] = v[msb];
		return r;
	endfunction

	// RV32I field layouts
	function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
	endfunction

	function automatic logic [31:0] expand_model(input logic [15:0] h);
		logic [31:0] w;
		logic [31:0] ci;
		logic [31:0] jo;
		logic [31:0] bo;
		logic [31:0] lo;
		logic [4:0]  rd;
		logic [4:0]  rs2;
		logic [4:0]  rdp;
		logic [4:0]  rs1p;
		logic [5:0]  sh;
		w    = '0;
		sh   = {h[12], h[6:2]};
		ci   = sext({26'd0, sh}, 5);
		jo   = sext({h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0}, 11);
		bo   = sext({h[12], h[6:5], h[2], h[11:10], h[4:3], 1'b0}, 8);
		lo   = {h[5], h[12:10], h[6], 2'b00};  // C.LW and C.SW offset
		rd   = h[11:7];
		rs2  = h[6:2];
		rdp  = 5'd8 + {2'b00, h[4:2]};
		rs1p = 5'd8 + {2'b00, h[9:7]};
		case ({h[1:0], h[15:13]})
			5'b00_000: if (h[12:5] != 8'd0)
				w = i_type({h[10:7], h[12:11], h[5], h[6], 2'b00}, 5'd2, 3'd0, rdp, `OPC_OP_IMM);
			5'b00_010: w = i_type(lo, rs1p, 3'd2, rdp, `OPC_LOAD);
			5'b00_110: w = s_type(lo, rdp, rs1p, 3'd2);
			5'b01_000: w = i_type(ci, rd, 3'd0, rd, `OPC_OP_IMM);
			5'b01_001: w = j_type(jo, 5'd1);
			5'b01_010: w = i_type(ci, 5'd0, 3'd0, rd, `OPC_OP_IMM);
			5'b01_011: begin
				if (sh != 6'd0 && rd == 5'd2)
					w = i_type(sext({h[12], h[4:3], h[5], h[2], h[6], 4'b0}, 9), 5'd2, 3'd0,
						5'd2, `OPC_OP_IMM);
				else if (sh != 6'd0)
					w = {ci[19:0], rd, `OPC_LUI};
			end
			5'b01_100: begin
				if (h[11:10] == 2'b10)
					w = i_type(ci, rs1p, 3'd7, rs1p, `OPC_OP_IMM);
				else if (!h[12] && h[11:10] == 2'b00)
					w = r_type(`F7_BASE, rs2, rs1p, 3'd5, rs1p, `OPC_OP_IMM);
				else if (!h[12] && h[11:10] == 2'b01)
					w = r_type(`F7_ALT, rs2, rs1p, 3'd5, rs1p, `OPC_OP_IMM);
				else if (!h[12])  // sub, xor, or, and
					w = r_type(h[6:5] == 2'b00 ? `F7_ALT : `F7_BASE, rdp, rs1p,
						{h[6] | h[5], h[6], h[6] & h[5]}, rs1p, `OPC_OP);
			end
			5'b01_101: w = j_type(jo, 5'd0);
			5'b01_110: w = b_type(bo, rs1p, 3'd0);
			5'b01_111: w = b_type(bo, rs1p, 3'd1);
			5'b10_000: if (!h[12])
				w = r_type(`F7_BASE, rs2, rd, 3'd1, rd, `OPC_OP_IMM);
			5'b10_010: if (rd != 5'd0)
				w = i_type({h[3:2], h[12], h[6:4], 2'b00}, 5'd2, 3'd2, rd, `OPC_LOAD);
			5'b10_100: begin
				if (rs2 != 5'd0)
					w = r_type(`F7_BASE, rs2, h[12] ? rd : 5'd0, 3'd0, rd, `OPC_OP);
				else if (rd != 5'd0)  // C.JR or C.JALR
					w = i_type(32'd0, rd, 3'd0, {4'd0, h[12]}, `OPC_JALR);
			end
			5'b10_110: w = s_type({h[8:7], h[12:9], 2'b00}, rs2, 5'd2, 3'd2);
			default: w = '0;
		endcase
		return w;
	endfunction

	function automatic rv_decode_pkg::decoded_t decode_model(input logic [31:0] w,
		input logic c);
		rv_decode_pkg::decoded_t d;
		logic [31:0]             i_imm;
		logic [2:0]              f3;
		f3           = w[14:12];
		i_imm        = sext({20'd0, w[31:20]}, 11);
		d.op         = rv_decode_pkg::op_illegal;
		d.imm        = '0;
		d.rd         = w[11:7];
		d.rs1        = w[19:15];
		d.rs2        = w[24:20];
		d.compressed = c;
		case (w[6:0])
			`OPC_LUI: begin
				d.op  = rv_decode_pkg::op_lui;
				d.imm = {w[31:12], 12'd0};
			end
			`OPC_AUIPC: begin
				d.op  = rv_decode_pkg::op_auipc;
				d.imm = {w[31:12], 12'd0};
			end
			`OPC_JAL: begin
				d.op  = rv_decode_pkg::op_jal;
				d.imm = sext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 20);
			end
			`OPC_JALR: if (f3 == 3'd0) begin
				d.op  = rv_decode_pkg::op_jalr;
				d.imm = i_imm;
			end
			`OPC_BRANCH: begin
				d.imm = sext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 12);
				case (f3)
					3'd0: d.op = rv_decode_pkg::op_beq;
					3'd1: d.op = rv_decode_pkg::op_bne;
					3'd4: d.op = rv_decode_pkg::op_blt;
					3'd5: d.op = rv_decode_pkg::op_bge;
					3'd6: d.op = rv_decode_pkg::op_bltu;
					3'd7: d.op = rv_decode_pkg::op_bgeu;
					default: d.op = rv_decode_pkg::op_illegal;
				endcase
			end
			`OPC_LOAD: begin
				d.imm = i_imm;
				case (f3)
					3'd0: d.op = rv_decode_pkg::op_lb;
					3'd1: d.op = rv_decode_pkg::op_lh;
					3'd2: d.op = rv_decode_pkg::op_lw;
					3'd4: d.op = rv_decode_pkg::op_lbu;
					3'd5: d.op = rv_decode_pkg::op_lhu;
					default: d.op = rv_decode_pkg::op_illegal;
				endcase
			end
			`OPC_STORE: begin
				d.imm = sext({20'd0, w[31:25], w[11:7]}, 11);
				case (f3)
					3'd0: d.op = rv_decode_pkg::op_sb;
					3'd1: d.op = rv_decode_pkg::op_sh;
					3'd2: d.op = rv_decode_pkg::op_sw;
					default: d.op = rv_decode_pkg::op_illegal;
				endcase
			end
			`OPC_OP_IMM: begin
				d.imm = i_imm;
				case ({w[31:25], f3})
					{`F7_BASE, 3'd1}: d.op = rv_decode_pkg::op_slli;
					{`F7_BASE, 3'd5}: d.op = rv_decode_pkg::op_srli;
					{`F7_ALT, 3'd5}:  d.op = rv_decode_pkg::op_srai;
					default: begin
						case (f3)
							3'd0: d.op = rv_decode_pkg::op_addi;
							3'd2: d.op = rv_decode_pkg::op_slti;
							3'd3: d.op = rv_decode_pkg::op_sltiu;
							3'd4: d.op = rv_decode_pkg::op_xori;
							3'd6: d.op = rv_decode_pkg::op_ori;
							3'd7: d.op = rv_decode_pkg::op_andi;
							default: d.op = rv_decode_pkg::op_illegal;  // Shift with bad funct7
						endcase
					end
				endcase
			end
			`OPC_OP: begin
				case ({w[31:25], f3})
					{`F7_BASE, 3'd0}: d.op = rv_decode_pkg::op_add;
					{`F7_ALT, 3'd0}:  d.op = rv_decode_pkg::op_sub;
					{`F7_BASE, 3'd1}: d.op = rv_decode_pkg::op_sll;
					{`F7_BASE, 3'd2}: d.op = rv_decode_pkg::op_slt;
					{`F7_BASE, 3'd3}: d.op = rv_decode_pkg::op_sltu;
					{`F7_BASE, 3'd4}: d.op = rv_decode_pkg::op_xor;
					{`F7_BASE, 3'd5}: d.op = rv_decode_pkg::op_srl;
					{`F7_ALT, 3'd5}:  d.op = rv_decode_pkg::op_sra;
					{`F7_BASE, 3'd6}: d.op = rv_decode_pkg::op_or;
					{`F7_BASE, 3'd7}: d.op = rv_decode_pkg::op_and;
					default: d.op = rv_decode_pkg::op_illegal;
				endcase
			end
			default: d.op = rv_decode_pkg::op_illegal;
		endcase
		return d;
	endfunction

	// Mostly legal 32-bit word, funct fields steered toward valid codes
	function automatic logic [31:0] legal_word(input logic [31:0] a, input logic [31:0] b);
		logic [6:0]  opc;
		logic [31:0] w;
		case (a % 9)
			0: opc = `OPC_LUI;
			1: opc = `OPC_AUIPC;
			2: opc = `OPC_JAL;
			3: opc = `OPC_JALR;
			4: opc = `OPC_BRANCH;
			5: opc = `OPC_LOAD;
			6: opc = `OPC_STORE;
			7: opc = `OPC_OP_IMM;
			default: opc = `OPC_OP;
		endcase
		w = {b[31:7], opc};
		case (opc)
			`OPC_JALR: w[14:12] = 3'd0;
			`OPC_BRANCH: if (w[14:13] == 2'b01) w[14] = 1'b1;
			`OPC_LOAD: if (w[14:12] inside {3'd3, 3'd6, 3'd7}) w[14:12] = 3'd2;
			`OPC_STORE: begin
				w[14] = 1'b0;
				if (w[13:12] == 2'b11)
					w[13:12] = 2'b10;
			end
			`OPC_OP_IMM: begin
				if (w[14:12] == 3'd1)
					w[31:25] = `F7_BASE;
				else if (w[14:12] == 3'd5)
					w[31:25] = a[20] ? `F7_ALT : `F7_BASE;
			end
			`OPC_OP: w[31:25] = (a[20] && w[14:12] inside {3'd0, 3'd5}) ? `F7_ALT : `F7_BASE;
			default: w = w;
		endcase
		return w;
	endfunction

	function automatic logic [31:0] compressed_word(input logic [31:0] a,
		input logic [31:0] b);
		logic [15:0] h;
		h = b[15:0];
		if (h[1:0] == 2'b11)
			h[1:0] = a[1] ? 2'b10 : {1'b0, a[0]};
		return {a[31:16], h};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		assert (actv === expv)
		else begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
			test_errors++;
		end
	endtask

	task automatic send_word(input logic [31:0] w, input bit must_be_illegal);
		logic [31:0] x;
		x = (w[1:0] == 2'b11) ? w : expand_model(w[15:0]);
		exp_q.push_back(decode_model(x, w[1:0] != 2'b11));
		illegal_q.push_back(must_be_illegal);
		push_count++;
		fetch_valid = 1'b1;
		fetch.word  = w;
		@(posedge clk);
		#2;
		fetch_valid = 1'b0;
	endtask

	task automatic idle_cycle();
		fetch_valid = 1'b0;
		fetch.word  = next_rand();  // Junk while idle
		@(posedge clk);
		#2;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 6) begin
			idle_cycle();
			n++;
		end
		assert (exp_q.size() == 0)
		else begin
			$display("%0d decoded words never came out", exp_q.size());
			test_errors++;
		end
	endtask

	task automatic check_outputs();
		rv_decode_pkg::decoded_t e;
		bit                      must_ill;
		check_value("dec_valid", {31'd0, fv_hist[1]}, {31'd0, dec_valid});
		fv_hist = {fv_hist[0], fetch_valid};
		if (dec_valid) begin
			pulse_count++;
			assert (exp_q.size() != 0)
			else begin
				$display("dec_valid pulse at %0t ns with no word outstanding", $time);
				test_errors++;
			end
			if (exp_q.size() != 0) begin
				e        = exp_q.pop_front();
				must_ill = illegal_q.pop_front();
				check_value("dec.op", {26'd0, e.op}, {26'd0, dec.op});
				check_value("dec.rd", {27'd0, e.rd}, {27'd0, dec.rd});
				check_value("dec.rs1", {27'd0, e.rs1}, {27'd0, dec.rs1});
				check_value("dec.rs2", {27'd0, e.rs2}, {27'd0, dec.rs2});
				check_value("dec.imm", e.imm, dec.imm);
				check_value("dec.compressed", {31'd0, e.compressed}, {31'd0, dec.compressed});
				if (must_ill)
					check_value("dec.op", 32'(rv_decode_pkg::op_illegal), {26'd0, dec.op});
			end
		end
	endtask

	always @(negedge clk) begin
		if (mon_en)
			check_outputs();
	end

	task automatic finish_test(input int num, input string name);
		if (test_errors == 0) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, test_errors);
			failed_tests++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int          i;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] k;
		resetn       = 1'b0;
		fetch_valid  = 1'b0;
		fetch        = '0;
		rng          = 32'd57237;
		fv_hist      = 2'b00;
		mon_en       = 1'b0;
		push_count   = 0;
		pulse_count  = 0;
		test_errors  = 0;
		total_errors = 0;
		failed_tests = 0;
		repeat (3) @(posedge clk);
		#2;
		resetn = 1'b1;
		mon_en = 1'b1;

		// dec_valid low and op cleared until the first fetch
		repeat (4) idle_cycle();
		@(negedge clk);
		check_value("dec.op", 32'(rv_decode_pkg::op_illegal), {26'd0, dec.op});
		@(posedge clk);
		#2;
		finish_test(1, "reset and idle");

		for (i = 0; i < N_LEGAL; i++) begin
			a = next_rand();
			b = next_rand();
			send_word(legal_word(a, b), 1'b0);
		end
		drain();
		finish_test(2, "legal 32-bit words");

		for (i = 0; i < N_COMP; i++) begin
			a = next_rand();
			b = next_rand();
			send_word(compressed_word(a, b), 1'b0);
		end
		drain();
		finish_test(3, "compressed words");

		for (i = 0; i < N_ILLEGAL; i++)
			send_word(illegal_words[i], 1'b1);
		drain();
		finish_test(4, "illegal words");

		for (i = 0; i < N_RAND; i++) begin
			a = next_rand();
			b = next_rand();
			k = next_rand();
			if (k[31:29] == 3'd0)  // Gap of one cycle
				idle_cycle();
			case (k % 3)
				0: send_word(legal_word(a, b), 1'b0);
				1: send_word(compressed_word(a, b), 1'b0);
				default: send_word(a, 1'b0);
			endcase
		end
		drain();
		assert (push_count == pulse_count)
		else begin
			$display("%0d words sent but %0d dec_valid pulses seen", push_count, pulse_count);
			test_errors++;
		end
		finish_test(5, "random stream with gaps");

		$display("%0d of 5 tests failed, %0d errors in total", failed_tests, total_errors);
		if (total_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
verilog/rv_decode_pkg.sv
verilog/rvc_expander.sv
verilog/opcode_classifier.sv
verilog/insn_decoder.sv
verilog/decode_control.sv
verilog/rv_decode_top.sv
sim/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module tb_top -o Vtb_top

# The simulator may exit nonzero on an RTL assertion, so the output decides
output=$(./obj_dir/Vtb_top 2>&1) || true
echo "$output"

if grep -qxF -- ">>> PASS" <<< "$output"; then
	exit 0
fi

echo "simulation did not report a pass"
exit 1
